/* all.f */
icache_pkg.sv
icache_tag_way.sv
icache_data_array.sv
icache_replace.sv
icache_ctrl.sv
icache_top.sv
tb_icache_mem.sv
tb_icache.sv

/* icache_ctrl.sv */
// fetch FSM of the cache: hit compare, instruction select, refill request and fence sweep.
`default_nettype none

module icache_ctrl (
    input  wire logic                           clk,
    input  wire logic                           rst_i,

    input  wire logic                           inst_req_i,
    input  wire logic [icache_pkg::addr_w-1:0]  inst_addr_i,
    input  wire logic                           fence_i,
    output logic                                inst_valid_o,
    output logic      [icache_pkg::insn_w-1:0]  inst_data_o,

    output logic                                mem_req_o,
    output logic      [icache_pkg::addr_w-1:0]  mem_addr_o,
    input  wire logic                           mem_valid_i,
    input  wire logic [icache_pkg::line_w-1:0]  mem_data_i,

    output logic      [icache_pkg::index_w-1:0] index_o,
    output logic      [icache_pkg::tag_w-1:0]   fill_tag_o,
    output logic                                fill0_o,
    output logic                                fill1_o,
    output logic                                clear_o,
    input  wire logic [icache_pkg::tag_w-1:0]   tag0_i,
    input  wire logic                           valid0_i,
    input  wire logic [icache_pkg::tag_w-1:0]   tag1_i,
    input  wire logic                           valid1_i,

    output icache_pkg::icache_line_u            fill_line_o,
    input  wire icache_pkg::icache_line_u       line0_i,
    input  wire icache_pkg::icache_line_u       line1_i,

    output logic                                touch_o,
    output logic                                touch_way_o,
    input  wire logic                           victim_i
);

    logic [1:0] state_q;
    logic [1:0] state_d;

    logic [icache_pkg::tag_w-1:0]   addr_tag;
    logic [icache_pkg::index_w-1:0] addr_index;

    logic hit0;
    logic hit1;
    logic hit;
    logic compare;
    logic fill_fire;
    logic fill_wait_q;
    logic hit_way_q;
    logic sweep;

    logic [icache_pkg::index_w:0]    fence_cnt_q;
    icache_pkg::icache_line_u        hit_line;
    logic [icache_pkg::insn_w-1:0]   hit_insn;

    assign addr_tag   = inst_addr_i[icache_pkg::addr_w-1 -: icache_pkg::tag_w];
    assign addr_index = inst_addr_i[icache_pkg::addr_w-icache_pkg::tag_w-1 -: icache_pkg::index_w];

    // storage outputs belong to the index presented one cycle earlier.
    assign hit0 = valid0_i && (tag0_i == addr_tag);
    assign hit1 = valid1_i && (tag1_i == addr_tag);
    assign hit  = hit0 || hit1;

    assign hit_line = hit0 ? line0_i : line1_i;
    assign hit_insn = hit_line.slot[inst_addr_i[2]];

    // the first lookup cycle after a fill still sees the old contents.
    assign compare = (state_q == icache_pkg::st_lookup) && !fill_wait_q;

    assign fill_fire = (state_q == icache_pkg::st_refill) && mem_valid_i;

    // sweep one set per cycle, only while no fetch is in flight.
    assign sweep = fence_i && (state_q == icache_pkg::st_idle)
                   && (fence_cnt_q < icache_pkg::sets);

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::st_idle: begin
                if (inst_req_i && !fence_i) begin
                    state_d = icache_pkg::st_lookup;
                end
            end
            icache_pkg::st_lookup: begin
                if (compare) begin
                    state_d = hit ? icache_pkg::st_respond : icache_pkg::st_refill;
                end
            end
            icache_pkg::st_respond: begin
                state_d = icache_pkg::st_idle;
            end
            icache_pkg::st_refill: begin
                if (mem_valid_i) begin
                    state_d = icache_pkg::st_lookup;
                end
            end
            default: begin
                state_d = icache_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q     <= icache_pkg::st_idle;
            fill_wait_q <= 1'b0;
            fence_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (fill_fire) begin
                fill_wait_q <= 1'b1;
            end else if (state_q == icache_pkg::st_lookup) begin
                fill_wait_q <= 1'b0;
            end
            if (!fence_i) begin
                fence_cnt_q <= '0;
            end else if (sweep) begin
                fence_cnt_q <= fence_cnt_q + 1'b1;
            end
        end
    end

    // response word and hit way, held for the respond cycle.
    always_ff @(posedge clk) begin
        if (compare && hit) begin
            inst_data_o <= hit_insn;
            hit_way_q   <= !hit0;
        end
    end

    assign inst_valid_o = (state_q == icache_pkg::st_respond);

    assign mem_req_o  = (state_q == icache_pkg::st_refill);
    assign mem_addr_o = {inst_addr_i[icache_pkg::addr_w-1:3], 3'b000};

    assign index_o    = sweep ? fence_cnt_q[icache_pkg::index_w-1:0] : addr_index;
    assign clear_o    = sweep;
    assign fill_tag_o = addr_tag;
    assign fill0_o    = fill_fire && !victim_i;
    assign fill1_o    = fill_fire && victim_i;

    always_comb begin
        fill_line_o.dword = mem_data_i;
    end

    // a fill and a delivered hit both count as use of the way.
    assign touch_o     = inst_valid_o || fill_fire;
    assign touch_way_o = fill_fire ? victim_i : hit_way_q;

    mem_align_a: assert property (@(posedge clk) disable iff (rst_i)
        mem_req_o |-> mem_addr_o[2:0] == 3'b000);

    // request and address stay put until memory answers.
    mem_hold_a: assert property (@(posedge clk) disable iff (rst_i)
        mem_req_o && !mem_valid_i |=> mem_req_o && $stable(mem_addr_o));

    valid_pulse_a: assert property (@(posedge clk) disable iff (rst_i)
        inst_valid_o |=> !inst_valid_o);

endmodule

`default_nettype wire

/* icache_data_array.sv */
// line storage for both ways, registered read, refill written into one way.
`default_nettype none

module icache_data_array (
    input  wire logic                           clk,
    input  wire logic [icache_pkg::index_w-1:0] index_i,
    input  wire logic                           we_way0_i,
    input  wire logic                           we_way1_i,
    input  wire icache_pkg::icache_line_u       fill_line_i,
    output icache_pkg::icache_line_u            line0_o,
    output icache_pkg::icache_line_u            line1_o
);

    icache_pkg::icache_line_u way0_mem [icache_pkg::sets];
    icache_pkg::icache_line_u way1_mem [icache_pkg::sets];

    // way 0 lines.
    always_ff @(posedge clk) begin
        if (we_way0_i) begin
            way0_mem[index_i] <= fill_line_i;
        end
        line0_o <= way0_mem[index_i];
    end

    // way 1 lines.
    always_ff @(posedge clk) begin
        if (we_way1_i) begin
            way1_mem[index_i] <= fill_line_i;
        end
        line1_o <= way1_mem[index_i];
    end

    // refill goes to exactly one victim way chosen by the replacement logic.
    one_way_write_a: assert property (@(posedge clk)
        !(we_way0_i && we_way1_i));

endmodule

`default_nettype wire

/* icache_pkg.sv */
// geometry constants, FSM encodings and the line type shared by every cache module.
`default_nettype none

package icache_pkg;

    // fetch address split: tag 31..9, index 8..3, slot 2.
    localparam int addr_w  = 32;
    localparam int tag_w   = 23;
    localparam int index_w = 6;
    localparam int sets    = 64;

    localparam int insn_w = 32;
    localparam int line_w = 64;

    // replacement age counters.
    localparam int age_w   = 3;
    localparam int age_max = 7;

    // fetch FSM states.
    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_lookup  = 2'd1;
    localparam logic [1:0] st_respond = 2'd2;
    localparam logic [1:0] st_refill  = 2'd3;

    // written whole on refill, read by slot on a hit.
    typedef union packed {
        logic [line_w-1:0]            dword;
        logic [1:0][insn_w-1:0]       slot;
    } icache_line_u;

endpackage

`default_nettype wire

/* icache_replace.sv */
// age-counter replacement state and victim selection for the two cache ways.
`default_nettype none

module icache_replace (
    input  wire logic                           clk,
    input  wire logic                           rst_i,
    input  wire logic [icache_pkg::index_w-1:0] index_i,
    input  wire logic                           valid0_i,
    input  wire logic                           valid1_i,
    input  wire logic                           touch_i,
    input  wire logic                           touch_way_i,
    output logic                                victim_o
);

    // first index is the way.
    logic [icache_pkg::age_w-1:0] age_q [2][icache_pkg::sets];

    logic [icache_pkg::age_w-1:0] age0;
    logic [icache_pkg::age_w-1:0] age1;

    function automatic logic [icache_pkg::age_w-1:0] sat_inc(
        input logic [icache_pkg::age_w-1:0] age
    );
        if (age == icache_pkg::age_max) begin
            return age;
        end
        return age + 1'b1;
    endfunction

    // a touch makes one counter youngest and ages all the others.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < icache_pkg::sets; s++) begin
                    age_q[w][s] <= '0;
                end
            end
        end else if (touch_i) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < icache_pkg::sets; s++) begin
                    if (s == int'(index_i) && w == int'(touch_way_i)) begin
                        age_q[w][s] <= '0;
                    end else begin
                        age_q[w][s] <= sat_inc(age_q[w][s]);
                    end
                end
            end
        end
    end

    assign age0 = age_q[0][index_i];
    assign age1 = age_q[1][index_i];

    // empty ways first, then the older way; ties go to way 0.
    always_comb begin
        if (!valid0_i) begin
            victim_o = 1'b0;
        end else if (!valid1_i) begin
            victim_o = 1'b1;
        end else begin
            victim_o = (age1 > age0);
        end
    end

endmodule

`default_nettype wire

/* icache_tag_way.sv */
// tag and valid storage of one cache way, one instance per way in the cache top.
`default_nettype none

module icache_tag_way (
    input  wire logic                          clk,
    input  wire logic                          rst_i,
    input  wire logic [icache_pkg::index_w-1:0] index_i,
    input  wire logic                          fill_i,
    input  wire logic [icache_pkg::tag_w-1:0]   fill_tag_i,
    input  wire logic                          clear_i,
    output logic      [icache_pkg::tag_w-1:0]   tag_o,
    output logic                               valid_o
);

    logic [icache_pkg::tag_w-1:0] tag_mem [icache_pkg::sets];
    logic [icache_pkg::sets-1:0]  valid_q;

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_mem[index_i] <= fill_tag_i;
        end
        tag_o <= tag_mem[index_i];
    end

    // valid bits, set by a fill and dropped by the fence sweep.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= '0;
            valid_o <= 1'b0;
        end else begin
            if (fill_i) begin
                valid_q[index_i] <= 1'b1;
            end else if (clear_i) begin
                valid_q[index_i] <= 1'b0;
            end
            valid_o <= valid_q[index_i];
        end
    end

    // the controller only sweeps while idle, never during a refill.
    fill_clear_excl_a: assert property (@(posedge clk) disable iff (rst_i)
        !(fill_i && clear_i));

endmodule

`default_nettype wire

/* icache_top.sv */
// two-way instruction cache top, joining the fetch FSM, tag ways, line storage and replacement.
`default_nettype none

module icache_top (
    input  wire logic                          clk,
    input  wire logic                          rst_i,
    input  wire logic                          inst_req_i,
    input  wire logic [icache_pkg::addr_w-1:0] inst_addr_i,
    input  wire logic                          fence_i,
    output logic                               inst_valid_o,
    output logic      [icache_pkg::insn_w-1:0] inst_data_o,
    output logic                               mem_req_o,
    output logic      [icache_pkg::addr_w-1:0] mem_addr_o,
    input  wire logic                          mem_valid_i,
    input  wire logic [icache_pkg::line_w-1:0] mem_data_i
);

    logic [icache_pkg::index_w-1:0] index;
    logic [icache_pkg::tag_w-1:0]   fill_tag;
    logic                           fill0;
    logic                           fill1;
    logic                           clear;
    logic [icache_pkg::tag_w-1:0]   tag0;
    logic [icache_pkg::tag_w-1:0]   tag1;
    logic                           valid0;
    logic                           valid1;
    icache_pkg::icache_line_u       fill_line;
    icache_pkg::icache_line_u       line0;
    icache_pkg::icache_line_u       line1;
    logic                           touch;
    logic                           touch_way;
    logic                           victim;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_req_i   (inst_req_i),
        .inst_addr_i  (inst_addr_i),
        .fence_i      (fence_i),
        .inst_valid_o (inst_valid_o),
        .inst_data_o  (inst_data_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_valid_i  (mem_valid_i),
        .mem_data_i   (mem_data_i),
        .index_o      (index),
        .fill_tag_o   (fill_tag),
        .fill0_o      (fill0),
        .fill1_o      (fill1),
        .clear_o      (clear),
        .tag0_i       (tag0),
        .valid0_i     (valid0),
        .tag1_i       (tag1),
        .valid1_i     (valid1),
        .fill_line_o  (fill_line),
        .line0_i      (line0),
        .line1_i      (line1),
        .touch_o      (touch),
        .touch_way_o  (touch_way),
        .victim_i     (victim)
    );

    // the sweep clears both ways at once.
    icache_tag_way u_tag_way0 (
        .clk        (clk),
        .rst_i      (rst_i),
        .index_i    (index),
        .fill_i     (fill0),
        .fill_tag_i (fill_tag),
        .clear_i    (clear),
        .tag_o      (tag0),
        .valid_o    (valid0)
    );

    icache_tag_way u_tag_way1 (
        .clk        (clk),
        .rst_i      (rst_i),
        .index_i    (index),
        .fill_i     (fill1),
        .fill_tag_i (fill_tag),
        .clear_i    (clear),
        .tag_o      (tag1),
        .valid_o    (valid1)
    );

    icache_data_array u_data_array (
        .clk         (clk),
        .index_i     (index),
        .we_way0_i   (fill0),
        .we_way1_i   (fill1),
        .fill_line_i (fill_line),
        .line0_o     (line0),
        .line1_o     (line1)
    );

    icache_replace u_replace (
        .clk         (clk),
        .rst_i       (rst_i),
        .index_i     (index),
        .valid0_i    (valid0),
        .valid1_i    (valid1),
        .touch_i     (touch),
        .touch_way_i (touch_way),
        .victim_o    (victim)
    );

endmodule

`default_nettype wire

/* tb_icache.sv */
// testbench top for the instruction cache, fetch sequences checked by concurrent assertions.
`default_nettype none

module tb_icache;

    localparam int fetch_count = 50;
    localparam int timeout     = (fetch_count * (8 + 10) + 2 * 65) * 40;

    logic        clk = 1'b0;
    logic        rst;
    logic        inst_req;
    logic [31:0] inst_addr;
    logic        fence;
    logic        inst_valid;
    logic [31:0] inst_data;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_valid;
    logic [63:0] mem_data;
    int          req_count;

    int    req_base;
    int    expect_reqs;
    logic  expect_hit;
    int    value_errors = 0;
    int    protocol_errors = 0;
    string test_name = "reset";

    always #20 clk = ~clk;

    icache_top dut_i (
        .clk          (clk),
        .rst_i        (rst),
        .inst_req_i   (inst_req),
        .inst_addr_i  (inst_addr),
        .fence_i      (fence),
        .inst_valid_o (inst_valid),
        .inst_data_o  (inst_data),
        .mem_req_o    (mem_req),
        .mem_addr_o   (mem_addr),
        .mem_valid_i  (mem_valid),
        .mem_data_i   (mem_data)
    );

    tb_icache_mem mem_i (
        .clk         (clk),
        .rst_i       (rst),
        .mem_req_i   (mem_req),
        .mem_addr_i  (mem_addr),
        .mem_valid_o (mem_valid),
        .mem_data_o  (mem_data),
        .req_count_o (req_count)
    );

    // instruction at addr under the memory pattern.
    function automatic logic [31:0] expect_insn(input logic [31:0] addr);
        logic [31:0] line_addr;
        line_addr = addr & 32'hffff_fff8;
        if (addr[2]) begin
            return (line_addr + 32'd4) ^ 32'h5a5a_0000;
        end
        return line_addr ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int index, input bit slot);
        return {tag[22:0], index[5:0], slot, 2'b00};
    endfunction

    data_check_a: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> inst_data == expect_insn(inst_addr))
    else begin
        value_errors++;
        $display("mismatch %s: addr %h expected %h actual %h", test_name,
                 $sampled(inst_addr), expect_insn($sampled(inst_addr)), $sampled(inst_data));
    end

    req_count_a: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> req_count - req_base == expect_reqs)
    else begin
        value_errors++;
        $display("mismatch %s: memory requests expected %0d actual %0d", test_name,
                 expect_reqs, $sampled(req_count) - req_base);
    end

    req_addr_a: assert property (@(posedge clk) disable iff (rst)
        mem_req |-> mem_addr == (inst_addr & 32'hffff_fff8))
    else begin
        value_errors++;
        $display("mismatch %s: memory address expected %h actual %h", test_name,
                 $sampled(inst_addr) & 32'hffff_fff8, $sampled(mem_addr));
    end

    hit_latency_a: assert property (@(posedge clk) disable iff (rst)
        expect_hit && $rose(inst_req) |-> ##2 inst_valid)
    else begin
        protocol_errors++;
        $display("%s: hit did not arrive in the second cycle after acceptance", test_name);
    end

    req_drop_a: assert property (@(posedge clk) disable iff (rst)
        mem_req && mem_valid |=> !mem_req)
    else begin
        protocol_errors++;
        $display("%s: memory request still high after the line was taken", test_name);
    end

    quiet_a: assert property (@(posedge clk) disable iff (rst)
        !inst_req |-> !inst_valid && !mem_req)
    else begin
        protocol_errors++;
        $display("%s: cache active without a fetch request", test_name);
    end

    task automatic fetch(input logic [31:0] addr, input int reqs);
        @(posedge clk);
        inst_req    <= 1'b1;
        inst_addr   <= addr;
        expect_reqs <= reqs;
        expect_hit  <= (reqs == 0);
        req_base    <= req_count;
        @(negedge clk);
        while (!inst_valid) begin
            @(negedge clk);
        end
        @(posedge clk);
        inst_req <= 1'b0;
    endtask

    initial begin
        #(timeout);
        $display("watchdog: run did not finish within %0d time units", timeout);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        inst_req    = 1'b0;
        inst_addr   = '0;
        fence       = 1'b0;
        expect_reqs = 0;
        expect_hit  = 1'b0;
        req_base    = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        test_name = "reset idle";
        repeat (10) @(posedge clk);

        test_name = "first fetch";
        fetch(make_addr(1, 2, 0), 1);
        fetch(make_addr(1, 2, 1), 0);
        fetch(make_addr(1, 2, 0), 0);

        test_name = "same index";
        fetch(make_addr(4, 9, 0), 1);
        fetch(make_addr(5, 9, 1), 1);
        repeat (2) begin
            fetch(make_addr(4, 9, 1), 0);
            fetch(make_addr(5, 9, 0), 0);
        end

        // c must take the way of b, the older one.
        test_name = "replacement";
        fetch(make_addr(6, 12, 0), 1);
        fetch(make_addr(7, 12, 0), 1);
        fetch(make_addr(6, 12, 1), 0);
        fetch(make_addr(8, 12, 0), 1);
        fetch(make_addr(6, 12, 0), 0);
        fetch(make_addr(7, 12, 1), 1);

        test_name = "random delays";
        for (int i = 0; i < 16; i++) begin
            fetch(make_addr(20 + i, 16 + i, i[0]), 1);
            fetch(make_addr(20 + i, 16 + i, !i[0]), 0);
        end

        test_name = "fence";
        @(posedge clk);
        fence <= 1'b1;
        repeat (65) @(posedge clk);
        fence <= 1'b0;
        fetch(make_addr(1, 2, 0), 1);
        fetch(make_addr(4, 9, 0), 1);
        fetch(make_addr(5, 9, 0), 1);

        repeat (4) @(posedge clk);
        $display("errors: %0d value mismatches, %0d protocol failures",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_icache_mem.sv */
// testbench memory model, answers each cache refill with one line after a random delay.
`default_nettype none

module tb_icache_mem (
    input  wire logic                          clk,
    input  wire logic                          rst_i,
    input  wire logic                          mem_req_i,
    input  wire logic [icache_pkg::addr_w-1:0] mem_addr_i,
    output logic                               mem_valid_o,
    output logic      [icache_pkg::line_w-1:0] mem_data_o,
    output int                                 req_count_o
);

    localparam logic [31:0] pattern = 32'h5a5a_0000;
    localparam logic [31:0] seed    = 32'h0000_5890;

    logic [31:0] lfsr_q;
    logic [31:0] addr_q;
    logic [3:0]  count_q;
    logic        busy_q;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // slot 0 in the low half.
    function automatic logic [63:0] line_for(input logic [31:0] line_addr);
        return {(line_addr + 32'd4) ^ pattern, line_addr ^ pattern};
    endfunction

    // quiet outputs before the first reset edge.
    initial begin
        mem_valid_o <= 1'b0;
        mem_data_o  <= '0;
    end

    always @(posedge clk) begin
        logic [31:0] s;
        logic [2:0]  delay;
        if (rst_i) begin
            lfsr_q      <= seed;
            busy_q      <= 1'b0;
            count_q     <= '0;
            addr_q      <= '0;
            mem_valid_o <= 1'b0;
            mem_data_o  <= '0;
            req_count_o <= 0;
        end else if (mem_valid_o) begin
            // the cache takes the line at this edge and drops its request.
            mem_valid_o <= 1'b0;
            busy_q      <= 1'b0;
        end else if (busy_q) begin
            if (count_q == 4'd1) begin
                mem_valid_o <= 1'b1;
                mem_data_o  <= line_for(addr_q);
            end else begin
                count_q <= count_q - 4'd1;
            end
        end else if (mem_req_i) begin
            s     = lfsr_q;
            delay = '0;
            // three bits give a delay of 1 to 8 cycles.
            for (int b = 0; b < 3; b++) begin
                delay = {delay[1:0], s[0]};
                s     = lfsr_step(s);
            end
            lfsr_q      <= s;
            count_q     <= {1'b0, delay} + 4'd1;
            addr_q      <= mem_addr_i;
            busy_q      <= 1'b1;
            req_count_o <= req_count_o + 1;
        end
    end

endmodule

`default_nettype wire
